//--- cordic_checker.sv
`timescale 1ns/100ps
`default_nettype none
`include "cordic_params.svh"

module cordic_checker (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  logic               ack,
  input  cordic_pkg::angle_t angle,
  input  logic               ready,
  input  cordic_pkg::word_t  cos_out,
  input  cordic_pkg::word_t  sin_out,
  input  logic               angle_error,
  output int                 mismatch_count,
  output int                 other_count
);

  localparam real pi = 3.141592653589793;
  localparam int tolerance = 6;
  localparam int op_cycle_limit = 200;
  localparam int pi_code = $rtoi(pi * (2.0 ** `CORDIC_ANGLE_FRAC) + 0.5);

  int                mismatches = 0;
  int                others = 0;
  int                cap_angle = 0;
  int                busy_cycles = 0;
  int                cos_ref;
  int                sin_ref;
  bit                busy = 1'b0;
  bit                expect_err = 1'b0;
  bit                ack_taken = 1'b0;
  logic              ready_prev = 1'b0;
  logic              err_prev = 1'b0;
  cordic_pkg::word_t cos_prev = '0;
  cordic_pkg::word_t sin_prev = '0;

  assign mismatch_count = mismatches;
  assign other_count    = others;

  function automatic int round_real(input real r);
    if (r >= 0.0) begin
      return $rtoi(r + 0.5);
    end
    return -$rtoi(0.5 - r);
  endfunction

  // cosine and sine of the angle code, rounded to result format.
  function automatic void ref_cos_sin(input int angle_code, output int c, output int s);
    real theta;
    theta = $itor(angle_code) / (2.0 ** `CORDIC_ANGLE_FRAC);
    c = round_real($cos(theta) * (2.0 ** `CORDIC_FRAC));
    s = round_real($sin(theta) * (2.0 ** `CORDIC_FRAC));
  endfunction

  task automatic check_close(input string name, input int expected, input int actual,
                             input int tol);
    int diff;
    diff = actual - expected;
    if (diff < 0) begin
      diff = -diff;
    end
    if (diff > tol) begin
      $display("mismatch at %0t: %s expected %0d got %0d", $time, name, expected, actual);
      mismatches++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("error at %0t: %s", $time, what);
    others++;
  endtask

  // sampled mid-cycle, where both DUT outputs and driven inputs are settled.
  always @(negedge clk) begin
    if (reset) begin
      check_close("ready", 0, int'(ready), 0);
      check_close("cos_out", 0, int'(cos_out), 0);
      check_close("sin_out", 0, int'(sin_out), 0);
      check_close("angle_error", 0, int'(angle_error), 0);
      busy       = 1'b0;
      expect_err = 1'b0;
      ack_taken  = 1'b0;
    end else begin
      if (ack_taken && ready) begin
        report_failure("ready stayed high after ack was taken");
      end
      if (ready_prev && !ready && !ack_taken) begin
        report_failure("ready fell before ack");
      end
      if (ready && !ready_prev) begin
        if (expect_err) begin
          report_failure("ready rose for an out-of-range angle");
        end else if (!busy) begin
          report_failure("ready rose with no operation pending");
        end else begin
          ref_cos_sin(cap_angle, cos_ref, sin_ref);
          check_close("cos_out", cos_ref, int'(cos_out), tolerance);
          check_close("sin_out", sin_ref, int'(sin_out), tolerance);
          check_close("angle_error", 0, int'(angle_error), 0);
        end
      end else begin
        // results only move when a new result is presented.
        check_close("cos_out", int'(cos_prev), int'(cos_out), 0);
        check_close("sin_out", int'(sin_prev), int'(sin_out), 0);
      end
      if (expect_err && angle_error && !err_prev) begin
        busy       = 1'b0;
        expect_err = 1'b0;
      end
      if (busy) begin
        busy_cycles++;
        if (busy_cycles > op_cycle_limit) begin
          report_failure("no result and no angle_error within the cycle limit after start");
          busy       = 1'b0;
          expect_err = 1'b0;
        end
      end
      if (start && !busy) begin
        cap_angle   = int'(angle);
        busy        = 1'b1;
        busy_cycles = 0;
        expect_err  = (cap_angle > pi_code) || (cap_angle < -pi_code);
      end
      ack_taken = ready && ack;
      if (ack_taken) begin
        busy = 1'b0;
      end
    end
    ready_prev = ready;
    err_prev   = angle_error;
    cos_prev   = cos_out;
    sin_prev   = sin_out;
  end

endmodule

`default_nettype wire

//--- cordic_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

interface cordic_ctrl_if;

  // enables from the controller.
  logic reset_reg;
  logic enab_rb1;
  logic enab_rb2;
  logic enab_rb3;
  logic enab_cont_var;
  logic enab_cont_iter;
  logic beg_add_subt;
  logic enab_out;

  // status back from the datapath.
  logic exception;
  logic max_tick_var;
  logic max_tick_iter;
  logic z_done;

  modport fsm (
    output reset_reg, enab_rb1, enab_rb2, enab_rb3,
    output enab_cont_var, enab_cont_iter, beg_add_subt, enab_out,
    input  exception, max_tick_var, max_tick_iter, z_done
  );

  modport datapath (
    input  reset_reg, enab_rb1, enab_rb2, enab_rb3,
    input  enab_cont_var, enab_cont_iter, beg_add_subt, enab_out,
    output exception, max_tick_var, max_tick_iter, z_done
  );

endinterface

`default_nettype wire

//--- cordic_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module cordic_fsm (
  input  logic       clk,
  input  logic       reset,
  input  logic       start,
  input  logic       ack,
  cordic_ctrl_if.fsm ctrl,
  output logic       ready
);

  typedef enum logic [2:0] {
    st_idle,
    st_capture,
    st_fold,
    st_load,
    st_var,
    st_wait_z,
    st_advance,
    st_hold
  } state_t;

  state_t state;
  state_t state_next;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next          = state;
    ctrl.reset_reg      = 1'b0;
    ctrl.enab_rb1       = 1'b0;
    ctrl.enab_rb2       = 1'b0;
    ctrl.enab_rb3       = 1'b0;
    ctrl.enab_cont_var  = 1'b0;
    ctrl.enab_cont_iter = 1'b0;
    ctrl.beg_add_subt   = 1'b0;
    ctrl.enab_out       = 1'b0;
    ready               = 1'b0;
    case (state)
      st_idle: begin
        ctrl.reset_reg = 1'b1;
        ctrl.enab_rb1  = 1'b1;
        if (start) begin
          state_next = st_capture;
        end
      end
      st_capture: begin
        ctrl.enab_rb1 = 1'b1;
        state_next    = st_fold;
      end
      st_fold: begin
        ctrl.enab_rb2 = 1'b1;
        // an out-of-range angle drops the run with no result.
        if (ctrl.exception) begin
          state_next = st_idle;
        end else begin
          state_next = st_load;
        end
      end
      st_load: begin
        ctrl.enab_rb3 = 1'b1;
        state_next    = st_var;
      end
      st_var: begin
        ctrl.enab_cont_var = 1'b1;
        ctrl.beg_add_subt  = 1'b1;
        if (ctrl.max_tick_var) begin
          state_next = st_wait_z;
        end
      end
      st_wait_z: begin
        ctrl.beg_add_subt = 1'b1;
        if (ctrl.z_done) begin
          state_next = st_advance;
        end
      end
      st_advance: begin
        ctrl.enab_cont_iter = 1'b1;
        ctrl.enab_cont_var  = 1'b1;
        if (ctrl.max_tick_iter) begin
          // latch the result on the way out so ready sees it.
          ctrl.enab_out = 1'b1;
          state_next    = st_hold;
        end else begin
          state_next = st_load;
        end
      end
      st_hold: begin
        ready = 1'b1;
        if (ack) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- cordic_iter_unit.sv
`timescale 1ns/100ps
`default_nettype none
`include "cordic_params.svh"

module cordic_iter_unit (
  input  logic               clk,
  input  logic               reset,
  input  cordic_pkg::vec_t   start_vec,
  cordic_ctrl_if.datapath    ctrl,
  output cordic_pkg::vec_t   vec
);

  cordic_pkg::word_t  x;
  cordic_pkg::word_t  y;
  cordic_pkg::angle_t z;
  cordic_pkg::word_t  x_op;
  cordic_pkg::word_t  y_op;
  cordic_pkg::iter_t  iter;
  logic               var_cnt;
  logic               z_done;
  logic               dir_pos;
  logic               z_phase;
  cordic_pkg::word_t  add_a;
  cordic_pkg::word_t  add_b;
  cordic_pkg::word_t  add_sum;
  logic               add_sub;

  // z step runs in the first wait cycle only.
  assign z_phase = ctrl.beg_add_subt && !ctrl.enab_cont_var && !z_done;

  // one adder, steered by phase and the variable counter.
  always_comb begin
    if (z_phase) begin
      add_a   = z;
      add_b   = cordic_pkg::atan_lut(iter);
      add_sub = dir_pos;
    end else if (!var_cnt) begin
      add_a   = x_op;
      add_b   = y_op >>> iter;
      add_sub = dir_pos;
    end else begin
      add_a   = y_op;
      add_b   = x_op >>> iter;
      add_sub = !dir_pos;
    end
  end

  assign add_sum = add_sub ? add_a - add_b : add_a + add_b;

  always_ff @(posedge clk) begin
    if (ctrl.enab_rb3) begin
      if (iter == '0) begin
        x    <= start_vec.x;
        y    <= start_vec.y;
        z    <= start_vec.z;
        x_op <= start_vec.x;
        y_op <= start_vec.y;
      end else begin
        // snapshot so the y step still sees the old x.
        x_op <= x;
        y_op <= y;
      end
    end else if (ctrl.enab_cont_var && ctrl.beg_add_subt) begin
      if (!var_cnt) begin
        x <= add_sum;
      end else begin
        y <= add_sum;
      end
    end else if (z_phase) begin
      z <= add_sum;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      iter    <= '0;
      var_cnt <= 1'b0;
      z_done  <= 1'b0;
      dir_pos <= 1'b1;
    end else begin
      z_done <= z_phase;
      if (ctrl.reset_reg) begin
        iter <= '0;
      end else if (ctrl.enab_cont_iter) begin
        iter <= iter + 1'b1;
      end
      if (ctrl.reset_reg || ctrl.enab_cont_iter) begin
        var_cnt <= 1'b0;
      end else if (ctrl.enab_cont_var) begin
        var_cnt <= !var_cnt;
      end
      if (ctrl.enab_rb3) begin
        dir_pos <= (iter == '0) ? !start_vec.z[`CORDIC_WIDTH-1] : !z[`CORDIC_WIDTH-1];
      end
    end
  end

  assign ctrl.max_tick_var  = var_cnt;
  assign ctrl.max_tick_iter = (iter == cordic_pkg::iter_t'(`CORDIC_ITERS - 1));
  assign ctrl.z_done        = z_done;

  assign vec.x = x;
  assign vec.y = y;
  assign vec.z = z;

endmodule

`default_nettype wire

//--- cordic_operand_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "cordic_params.svh"

module cordic_operand_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  cordic_pkg::angle_t   angle,
  cordic_ctrl_if.datapath      ctrl,
  output cordic_pkg::vec_t     start_vec,
  output logic                 negate,
  output logic                 angle_error
);

  localparam int angle_pi =
    $rtoi(3.141592653589793 * (2.0 ** `CORDIC_ANGLE_FRAC) + 0.5);
  localparam int angle_half_pi = angle_pi / 2;

  cordic_pkg::angle_t angle_q;
  cordic_pkg::angle_t z_fold;
  logic               pos_fold;
  logic               neg_fold;

  // angle follows the input only while idle.
  always_ff @(posedge clk) begin
    if (ctrl.enab_rb1 && ctrl.reset_reg) begin
      angle_q <= angle;
    end
    if (ctrl.enab_rb1) begin
      pos_fold <= angle_q > angle_half_pi;
      neg_fold <= angle_q < -angle_half_pi;
    end
    if (ctrl.enab_rb2) begin
      if (pos_fold) begin
        z_fold <= angle_q - cordic_pkg::angle_t'(angle_pi);
      end else if (neg_fold) begin
        z_fold <= angle_q + cordic_pkg::angle_t'(angle_pi);
      end else begin
        z_fold <= angle_q;
      end
    end
  end

  assign ctrl.exception = (angle_q > angle_pi) || (angle_q < -angle_pi);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      negate      <= 1'b0;
      angle_error <= 1'b0;
    end else begin
      if (ctrl.enab_rb2) begin
        negate <= pos_fold || neg_fold;
      end
      // sticky until the next run is captured.
      if (ctrl.enab_rb2 && ctrl.exception) begin
        angle_error <= 1'b1;
      end else if (ctrl.enab_rb1 && !ctrl.reset_reg) begin
        angle_error <= 1'b0;
      end
    end
  end

  assign start_vec.x = cordic_pkg::cordic_gain;
  assign start_vec.y = '0;
  assign start_vec.z = z_fold;

endmodule

`default_nettype wire

//--- cordic_params.svh
`ifndef CORDIC_PARAMS_SVH
`define CORDIC_PARAMS_SVH

// width of every data and angle word.
`define CORDIC_WIDTH 16

// fraction bits of cosine and sine, and of the angle.
`define CORDIC_FRAC 14
`define CORDIC_ANGLE_FRAC 13

`define CORDIC_ITERS 14

`endif

//--- cordic_pkg.sv
`default_nettype none
`include "cordic_params.svh"

package cordic_pkg;

  typedef logic signed [`CORDIC_WIDTH-1:0] word_t;
  typedef logic signed [`CORDIC_WIDTH-1:0] angle_t;

  typedef struct packed {
    word_t  x;
    word_t  y;
    angle_t z;
  } vec_t;

  typedef logic [$clog2(`CORDIC_ITERS)-1:0] iter_t;

  // 1/K for an unbounded number of iterations, in result format.
  localparam word_t cordic_gain =
    word_t'($rtoi(0.6072529350088813 * (2.0 ** `CORDIC_FRAC) + 0.5));

  // atan(2^-i) with 13 fraction bits.
  function automatic angle_t atan_lut(input iter_t i);
    case (i)
      4'd0:    return angle_t'(6434);
      4'd1:    return angle_t'(3798);
      4'd2:    return angle_t'(2007);
      4'd3:    return angle_t'(1019);
      4'd4:    return angle_t'(511);
      4'd5:    return angle_t'(256);
      4'd6:    return angle_t'(128);
      4'd7:    return angle_t'(64);
      4'd8:    return angle_t'(32);
      4'd9:    return angle_t'(16);
      4'd10:   return angle_t'(8);
      4'd11:   return angle_t'(4);
      4'd12:   return angle_t'(2);
      4'd13:   return angle_t'(1);
      default: return '0;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- cordic_result_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module cordic_result_buffer (
  input  logic               clk,
  input  logic               reset,
  input  cordic_pkg::vec_t   vec,
  input  logic               negate,
  cordic_ctrl_if.datapath    ctrl,
  output cordic_pkg::word_t  cos_out,
  output cordic_pkg::word_t  sin_out
);

  cordic_pkg::word_t cos_fix;
  cordic_pkg::word_t sin_fix;

  // a folded angle flips the sign of both terms.
  assign cos_fix = negate ? -vec.x : vec.x;
  assign sin_fix = negate ? -vec.y : vec.y;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cos_out <= '0;
      sin_out <= '0;
    end else if (ctrl.enab_out) begin
      cos_out <= cos_fix;
      sin_out <= sin_fix;
    end
  end

endmodule

`default_nettype wire

//--- cordic_top.sv
`timescale 1ns/100ps
`default_nettype none

module cordic_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  logic               ack,
  input  cordic_pkg::angle_t angle,
  output logic               ready,
  output cordic_pkg::word_t  cos_out,
  output cordic_pkg::word_t  sin_out,
  output logic               angle_error
);

  cordic_pkg::vec_t start_vec;
  cordic_pkg::vec_t vec;
  logic             negate;

  cordic_ctrl_if ctrl_if ();

  cordic_fsm cordic_fsm_inst (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .ack   (ack),
    .ctrl  (ctrl_if.fsm),
    .ready (ready)
  );

  cordic_operand_stage cordic_operand_stage_inst (
    .clk         (clk),
    .reset       (reset),
    .angle       (angle),
    .ctrl        (ctrl_if.datapath),
    .start_vec   (start_vec),
    .negate      (negate),
    .angle_error (angle_error)
  );

  cordic_iter_unit cordic_iter_unit_inst (
    .clk       (clk),
    .reset     (reset),
    .start_vec (start_vec),
    .ctrl      (ctrl_if.datapath),
    .vec       (vec)
  );

  cordic_result_buffer cordic_result_buffer_inst (
    .clk     (clk),
    .reset   (reset),
    .vec     (vec),
    .negate  (negate),
    .ctrl    (ctrl_if.datapath),
    .cos_out (cos_out),
    .sin_out (sin_out)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the CORDIC testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_cordic -o tb_cordic
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_cordic)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1

//--- sim.f
+incdir+.
cordic_pkg.sv
cordic_ctrl_if.sv
cordic_fsm.sv
cordic_operand_stage.sv
cordic_iter_unit.sv
cordic_result_buffer.sv
cordic_top.sv
cordic_checker.sv
tb_cordic.sv

//--- tb_cordic.sv
`timescale 1ns/100ps
`default_nettype none
`include "cordic_params.svh"

module tb_cordic;

  localparam int  clk_period = 100;
  localparam int  drive_delay = 10;
  localparam int  num_fixed = 12;
  localparam int  num_random = 200;
  localparam int  num_error_ops = 5;
  localparam int  num_ops = num_fixed + num_random + num_error_ops;
  localparam int  wait_limit = 200;
  localparam int  watchdog_cycles = num_ops * 200 + 1000;
  localparam real pi = 3.141592653589793;

  logic               clk;
  logic               reset;
  logic               start;
  logic               ack;
  cordic_pkg::angle_t angle;
  logic               ready;
  cordic_pkg::word_t  cos_out;
  cordic_pkg::word_t  sin_out;
  logic               angle_error;
  int                 mismatch_count;
  int                 other_count;

  cordic_top cordic_top_inst (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .ack         (ack),
    .angle       (angle),
    .ready       (ready),
    .cos_out     (cos_out),
    .sin_out     (sin_out),
    .angle_error (angle_error)
  );

  cordic_checker cordic_checker_inst (
    .clk            (clk),
    .reset          (reset),
    .start          (start),
    .ack            (ack),
    .angle          (angle),
    .ready          (ready),
    .cos_out        (cos_out),
    .sin_out        (sin_out),
    .angle_error    (angle_error),
    .mismatch_count (mismatch_count),
    .other_count    (other_count)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic int angle_code(input real rad);
    real scaled;
    scaled = rad * (2.0 ** `CORDIC_ANGLE_FRAC);
    if (scaled >= 0.0) begin
      return $rtoi(scaled + 0.5);
    end
    return -$rtoi(0.5 - scaled);
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #(drive_delay);
  endtask

  task automatic run_legal(input int code, input int ack_delay);
    int cycles;
    angle = cordic_pkg::angle_t'(code);
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    cycles = 0;
    while (!ready && cycles < wait_limit) begin
      next_cycle();
      cycles++;
    end
    if (ready) begin
      repeat (ack_delay) next_cycle();
      ack = 1'b1;
      next_cycle();
      ack = 1'b0;
    end
  endtask

  task automatic run_illegal(input int code);
    int   cycles;
    logic err_seen;
    angle = cordic_pkg::angle_t'(code);
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    err_seen = angle_error;
    cycles = 0;
    // the flag can still be set from an earlier run, so wait for a fresh rise.
    while (!(angle_error && !err_seen) && cycles < wait_limit) begin
      err_seen = angle_error;
      next_cycle();
      cycles++;
    end
  endtask

  initial begin
    int code;
    int limit;
    clk   = 1'b0;
    reset = 1'b1;
    start = 1'b0;
    ack   = 1'b0;
    angle = '0;
    void'($urandom(32'hb72042a2));
    limit = angle_code(pi);
    repeat (2) @(posedge clk);
    #(drive_delay);
    reset = 1'b0;
    // ack with nothing pending.
    ack = 1'b1;
    repeat (3) next_cycle();
    ack = 1'b0;
    next_cycle();
    run_legal(angle_code(0.0), 0);
    run_legal(angle_code(pi / 6.0), 1);
    run_legal(angle_code(pi / 4.0), 2);
    run_legal(angle_code(pi / 3.0), 0);
    run_legal(angle_code(pi / 2.0), 3);
    run_legal(angle_code(-pi / 4.0), 0);
    // beyond pi/2 either way, so the fold is applied.
    run_legal(angle_code(2.0), 0);
    run_legal(angle_code(2.6), 1);
    run_legal(angle_code(3.1), 0);
    run_legal(angle_code(-1.8), 2);
    run_legal(angle_code(-2.5), 0);
    run_legal(angle_code(-3.1), 1);
    repeat (num_random) begin
      code = int'($urandom_range(2 * limit)) - limit;
      run_legal(code, int'($urandom_range(5)));
    end
    run_illegal(angle_code(3.3));
    run_legal(angle_code(1.0), 2);
    run_illegal(angle_code(-3.5));
    run_illegal(32767);
    run_legal(angle_code(-0.7), 0);
    repeat (3) next_cycle();
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire
